//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_decode
FILELIST ?= list.f
BUILD_DIR ?= obj_dir
PASS_MSG ?= All tests passed
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/100ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- list.f
rtl/isa_pkg.sv
rtl/decode_pkg.sv
rtl/d_format_decoder.sv
rtl/ds_format_decoder.sv
rtl/dq_format_decoder.sv
rtl/decode_merge.sv
rtl/ppc_load_store_decode.sv
sim/decode_asserts.sv
sim/tb_decode.sv

//--- rtl/d_format_decoder.sv
`timescale 1ns/100ps

module d_format_decoder
	import isa_pkg::*, decode_pkg::*;
(
	input logic [0:inst_width_c-1] instr_i,
	output decode_cand_t cand_o
);

	primary_op_e opcode;
	logic [disp_msb_c:d_disp_lsb_c] d_field;

	assign opcode = primary_op_e'(instr_i[op_msb_c:op_lsb_c]);
	assign d_field = instr_i[disp_msb_c:d_disp_lsb_c];

	always_comb
	begin
		cand_o = '0;

		// Name the operation from the primary opcode alone
		case (opcode)
			addi: cand_o.op = op_addi;
			addis: cand_o.op = op_addis;
			ori: cand_o.op = op_ori;
			lwz: cand_o.op = op_lwz;
			lbz: cand_o.op = op_lbz;
			stw: cand_o.op = op_stw;
			stb: cand_o.op = op_stb;
			default: cand_o.op = op_none;
		endcase

		if (cand_o.op != op_none)
		begin
			cand_o.claim = 1'b1;
			cand_o.rt = instr_i[rt_msb_c:rt_lsb_c]; // RT for loads and arithmetic, RS for stores
			cand_o.ra = instr_i[ra_msb_c:ra_lsb_c];

			// ori is a logical op, RA is always a real register there
			cand_o.ra_or_zero = (cand_o.op != op_ori);

			case (cand_o.op)
				op_ori:
				begin
					cand_o.imm = {{(imm_width_c - $bits(d_field)){1'b0}}, d_field}; // UI field
				end
				op_addis:
				begin
					// SI || 0x0000, then sign extended from bit 32
					cand_o.imm = {{(imm_width_c - $bits(d_field) - 16){d_field[disp_msb_c]}},
						d_field, 16'h0000};
				end
				default:
				begin
					cand_o.imm = {{(imm_width_c - $bits(d_field)){d_field[disp_msb_c]}}, d_field};
				end
			endcase
		end
	end

endmodule

//--- rtl/decode_merge.sv
`timescale 1ns/100ps

module decode_merge
	import decode_pkg::*;
(
	input logic clock_i,
	input logic arst_n_i,
	input logic valid_i,
	input decode_cand_t d_cand_i,
	input decode_cand_t ds_cand_i,
	input decode_cand_t dq_cand_i,
	output logic valid_o,
	output decoded_inst_t inst_o
);

	decode_cand_t sel_cand;
	decoded_inst_t next_inst;

	// The decoders never claim the same word, so the order here is arbitrary
	always_comb
	begin
		if (d_cand_i.claim)
			sel_cand = d_cand_i;
		else if (ds_cand_i.claim)
			sel_cand = ds_cand_i;
		else if (dq_cand_i.claim)
			sel_cand = dq_cand_i;
		else
			sel_cand = '0;
	end

	always_comb
	begin
		next_inst = '0; // Unclaimed words carry only the illegal flag
		next_inst.illegal = !sel_cand.claim;
		if (sel_cand.claim)
		begin
			next_inst.op = sel_cand.op;
			next_inst.rt = sel_cand.rt;
			next_inst.ra = sel_cand.ra;
			next_inst.ra_or_zero = sel_cand.ra_or_zero;
			next_inst.imm = sel_cand.imm;
			next_inst.tx = sel_cand.tx;
		end
	end

	always_ff @(posedge clock_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			valid_o <= 1'b0;
			inst_o <= '0;
		end
		else
		begin
			valid_o <= valid_i;
			if (valid_i)
				inst_o <= next_inst; // Holds its last value across idle cycles
		end
	end

endmodule

//--- rtl/decode_pkg.sv
package decode_pkg;

	import isa_pkg::*;

	// Operation named by the decode stage, op_none marks an unclaimed word
	typedef enum logic [4:0]
	{
		op_none,
		op_addi,
		op_addis,
		op_ori,
		op_lwz,
		op_lbz,
		op_stw,
		op_stb,
		op_ld,
		op_ldu,
		op_lwa,
		op_std,
		op_stdu,
		op_lq,
		op_lxv,
		op_stxv
	} decoded_op_e;

	// Result of one format decoder, all fields are zero when claim is low
	typedef struct packed
	{
		logic claim; // This decoder recognises the word
		decoded_op_e op;
		logic [0:reg_width_c-1] rt;
		logic [0:reg_width_c-1] ra;
		logic ra_or_zero; // RA of 0 reads as the literal zero
		logic [0:imm_width_c-1] imm;
		logic tx; // VSX register extension bit
	} decode_cand_t;

	// Registered output of the stage
	typedef struct packed
	{
		logic illegal; // No decoder claimed the word
		decoded_op_e op;
		logic [0:reg_width_c-1] rt;
		logic [0:reg_width_c-1] ra;
		logic ra_or_zero;
		logic [0:imm_width_c-1] imm;
		logic tx;
	} decoded_inst_t;

endpackage

//--- rtl/dq_format_decoder.sv
`timescale 1ns/100ps

module dq_format_decoder
	import isa_pkg::*, decode_pkg::*;
(
	input logic [0:inst_width_c-1] instr_i,
	output decode_cand_t cand_o
);

	primary_op_e opcode;
	dq_xo_e xo;
	logic [disp_msb_c:dq_disp_lsb_c] dq_field;

	assign opcode = primary_op_e'(instr_i[op_msb_c:op_lsb_c]);
	assign xo = dq_xo_e'(instr_i[dq_xo_msb_c:dq_xo_lsb_c]);
	assign dq_field = instr_i[disp_msb_c:dq_disp_lsb_c];

	always_comb
	begin
		cand_o = '0;

		// lq ignores bits 28 to 31, only the VSX primary splits on xo
		case (opcode)
			lq: cand_o.op = op_lq;
			dq_vsx:
				case (xo)
					dq_xo_lxv: cand_o.op = op_lxv;
					dq_xo_stxv: cand_o.op = op_stxv;
					default: cand_o.op = op_none;
				endcase
			default: cand_o.op = op_none;
		endcase

		if (cand_o.op != op_none)
		begin
			cand_o.claim = 1'b1;
			cand_o.rt = instr_i[rt_msb_c:rt_lsb_c]; // RTp for lq, low VSR bits for the vector forms
			cand_o.ra = instr_i[ra_msb_c:ra_lsb_c];
			cand_o.ra_or_zero = 1'b1;
			cand_o.imm = {{(imm_width_c - $bits(dq_field) - 4){dq_field[disp_msb_c]}},
				dq_field, 4'b0000}; // Quadword-aligned displacement

			// TX selects the upper half of the 64-entry VSR file
			cand_o.tx = (cand_o.op != op_lq) && instr_i[dq_tx_c];
		end
	end

endmodule

//--- rtl/ds_format_decoder.sv
`timescale 1ns/100ps

module ds_format_decoder
	import isa_pkg::*, decode_pkg::*;
(
	input logic [0:inst_width_c-1] instr_i,
	output decode_cand_t cand_o
);

	primary_op_e opcode;
	ds_xo_e xo;
	logic [disp_msb_c:ds_disp_lsb_c] ds_field;

	assign opcode = primary_op_e'(instr_i[op_msb_c:op_lsb_c]);
	assign xo = ds_xo_e'(instr_i[ds_xo_msb_c:ds_xo_lsb_c]);
	assign ds_field = instr_i[disp_msb_c:ds_disp_lsb_c];

	always_comb
	begin
		cand_o = '0;

		case (opcode)
			ds_load:
				case (xo)
					ds_xo_d: cand_o.op = op_ld;
					ds_xo_du: cand_o.op = op_ldu;
					ds_xo_wa: cand_o.op = op_lwa;
					default: cand_o.op = op_none; // xo 3 is reserved
				endcase
			ds_store:
				case (xo)
					ds_xo_d: cand_o.op = op_std;
					ds_xo_du: cand_o.op = op_stdu;
					default: cand_o.op = op_none; // No word-algebraic store exists
				endcase
			default: cand_o.op = op_none;
		endcase

		if (cand_o.op != op_none)
		begin
			cand_o.claim = 1'b1;
			cand_o.rt = instr_i[rt_msb_c:rt_lsb_c];
			cand_o.ra = instr_i[ra_msb_c:ra_lsb_c];
			cand_o.ra_or_zero = !(cand_o.op inside {op_ldu, op_stdu}); // Update forms write RA back
			cand_o.imm = {{(imm_width_c - $bits(ds_field) - 2){ds_field[disp_msb_c]}},
				ds_field, 2'b00}; // Word-aligned displacement
		end
	end

endmodule

//--- rtl/isa_pkg.sv
package isa_pkg;

	// Power ISA word and register geometry
	localparam int inst_width_c = 32;
	localparam int reg_width_c = 5; // GPR and VSR specifier width
	localparam int imm_width_c = 64; // Immediates are extended to the full register width
	localparam int op_width_c = 6; // Primary opcode width
	localparam int ds_xo_width_c = 2;
	localparam int dq_xo_width_c = 3;

	// Field positions use big-endian numbering, bit 0 is the most significant bit
	localparam int op_msb_c = 0;
	localparam int op_lsb_c = 5;
	localparam int rt_msb_c = 6; // RT, RS, TX-less VSR number or RTp
	localparam int rt_lsb_c = 10;
	localparam int ra_msb_c = 11;
	localparam int ra_lsb_c = 15;

	// Displacement fields all start at bit 16 and end where the form's xo begins
	localparam int disp_msb_c = 16;
	localparam int d_disp_lsb_c = 31; // D form, full 16-bit D field
	localparam int ds_disp_lsb_c = 29; // DS form, 14-bit DS field
	localparam int dq_disp_lsb_c = 27; // DQ form, 12-bit DQ field

	// Extended opcode and extension bit positions
	localparam int ds_xo_msb_c = 30;
	localparam int ds_xo_lsb_c = 31;
	localparam int dq_tx_c = 28; // Upper bit of the 6-bit VSR number
	localparam int dq_xo_msb_c = 29;
	localparam int dq_xo_lsb_c = 31;

	// Primary opcodes handled by this stage
	typedef enum logic [op_width_c-1:0]
	{
		addi = 6'd14,
		addis = 6'd15,
		ori = 6'd24,
		lwz = 6'd32,
		lbz = 6'd34,
		stw = 6'd36,
		stb = 6'd38,
		lq = 6'd56,
		ds_load = 6'd58, // ld, ldu, lwa
		dq_vsx = 6'd61, // lxv, stxv
		ds_store = 6'd62 // std, stdu
	} primary_op_e;

	// DS form extended opcodes, value 3 is reserved under both primaries
	typedef enum logic [ds_xo_width_c-1:0]
	{
		ds_xo_d = 2'd0, // ld or std
		ds_xo_du = 2'd1, // ldu or stdu
		ds_xo_wa = 2'd2 // lwa, only under opcode 58
	} ds_xo_e;

	// DQ form extended opcodes under primary 61
	typedef enum logic [dq_xo_width_c-1:0]
	{
		dq_xo_lxv = 3'd1,
		dq_xo_stxv = 3'd5
	} dq_xo_e;

endpackage

//--- rtl/ppc_load_store_decode.sv
`timescale 1ns/100ps

module ppc_load_store_decode
	import isa_pkg::*, decode_pkg::*;
(
	input logic clock_i,
	input logic arst_n_i,
	input logic valid_i,
	input logic [0:inst_width_c-1] instr_i,
	output logic valid_o,
	output decoded_inst_t inst_o
);

	decode_cand_t d_cand;
	decode_cand_t ds_cand;
	decode_cand_t dq_cand;

	// All three formats look at the same word in the same cycle
	d_format_decoder i_d_dec
	(
		.instr_i(instr_i),
		.cand_o(d_cand)
	);

	ds_format_decoder i_ds_dec
	(
		.instr_i(instr_i),
		.cand_o(ds_cand)
	);

	dq_format_decoder i_dq_dec
	(
		.instr_i(instr_i),
		.cand_o(dq_cand)
	);

	decode_merge i_merge
	(
		.clock_i(clock_i),
		.arst_n_i(arst_n_i),
		.valid_i(valid_i),
		.d_cand_i(d_cand),
		.ds_cand_i(ds_cand),
		.dq_cand_i(dq_cand),
		.valid_o(valid_o),
		.inst_o(inst_o)
	);

endmodule

//--- sim/decode_asserts.sv
`timescale 1ns/100ps

module decode_asserts
	import decode_pkg::*;
(
	input logic clock_i,
	input logic arst_n_i,
	input logic valid_i,
	input decode_cand_t d_cand_i,
	input decode_cand_t ds_cand_i,
	input decode_cand_t dq_cand_i,
	input logic valid_o,
	input decoded_inst_t inst_o
);

	int fail_count = 0;

	// Fixed latency of one cycle, idle cycles pass straight through
	valid_latency: assert property (@(posedge clock_i) disable iff (!arst_n_i)
		valid_o == $past(valid_i))
	else
	begin
		$error("valid_o does not match valid_i of the previous cycle");
		fail_count++;
	end

	one_claim: assert property (@(posedge clock_i) disable iff (!arst_n_i)
		$onehot0({d_cand_i.claim, ds_cand_i.claim, dq_cand_i.claim}))
	else
	begin
		$error("More than one format decoder claims the same word");
		fail_count++;
	end

	illegal_is_none: assert property (@(posedge clock_i) disable iff (!arst_n_i)
		valid_o && inst_o.illegal |-> inst_o.op == op_none)
	else
	begin
		$error("An illegal result carries an operation other than op_none");
		fail_count++;
	end

endmodule

//--- sim/tb_decode.sv
`timescale 1ns/100ps

module tb_decode
	import decode_pkg::*;
();

	localparam int reset_len_c = 3;
	localparam int directed_len_c = 46; // 15 instructions with three displacements each and one drain
	localparam int edge_len_c = 10;
	localparam int random_len_c = 1000;
	localparam int gap_len_c = 120;
	localparam int mid_half_c = 30;
	localparam int total_cycles_c = 2 * reset_len_c + directed_len_c + edge_len_c
		+ random_len_c + gap_len_c + 2 * mid_half_c + 3;
	localparam int timeout_c = total_cycles_c + 50;

	// Opcode of each named instruction, the low bits its form fixes, and their value
	localparam logic [5:0] dir_op_c [15] = '{6'd14, 6'd15, 6'd24, 6'd32, 6'd34, 6'd36, 6'd38,
		6'd58, 6'd58, 6'd58, 6'd62, 6'd62, 6'd56, 6'd61, 6'd61};
	localparam logic [3:0] dir_mask_c [15] = '{4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0,
		4'h3, 4'h3, 4'h3, 4'h3, 4'h3, 4'h0, 4'h7, 4'h7};
	localparam logic [3:0] dir_val_c [15] = '{4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0,
		4'h0, 4'h1, 4'h2, 4'h0, 4'h1, 4'h0, 4'h1, 4'h5};
	localparam logic [5:0] edge_op_c [9] = '{6'd58, 6'd62, 6'd62, 6'd61, 6'd61, 6'd61,
		6'd61, 6'd61, 6'd61};
	localparam logic [2:0] edge_xo_c [9] = '{3'd3, 3'd3, 3'd2, 3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
	localparam logic [5:0] supported_ops_c [11] = '{6'd14, 6'd15, 6'd24, 6'd32, 6'd34, 6'd36,
		6'd38, 6'd56, 6'd58, 6'd61, 6'd62};

	logic clock_i = 1'b0;
	logic arst_n_i;
	logic valid_i;
	logic [31:0] instr_i;
	logic valid_o;
	decoded_inst_t inst_o;
	logic [31:0] rng_state = 32'h6e92;
	int cycle_count = 0;
	int value_errors = 0;
	int other_errors = 0;
	logic exp_valid_q [$];
	decoded_inst_t exp_inst_q [$];
	string exp_name_q [$];

	ppc_load_store_decode i_dut
	(
		.clock_i(clock_i),
		.arst_n_i(arst_n_i),
		.valid_i(valid_i),
		.instr_i(instr_i),
		.valid_o(valid_o),
		.inst_o(inst_o)
	);

	bind decode_merge decode_asserts i_asserts
	(
		.clock_i(clock_i),
		.arst_n_i(arst_n_i),
		.valid_i(valid_i),
		.d_cand_i(d_cand_i),
		.ds_cand_i(ds_cand_i),
		.dq_cand_i(dq_cand_i),
		.valid_o(valid_o),
		.inst_o(inst_o)
	);

	always #2 clock_i = !clock_i;

	always @(posedge clock_i)
	begin
		cycle_count++;
		if (cycle_count > timeout_c)
		begin
			$display("The run did not finish within %0d clock cycles", timeout_c);
			$display("Some tests failed");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state ^ (rng_state >> 16); // Fold the stronger upper bits downward
	endfunction

	// Half of the words get an opcode this stage knows, the rest keep a random one
	function automatic logic [31:0] rand_word();
		logic [31:0] word;
		logic [31:0] pick;
		logic [3:0] idx;
		word = next_rand();
		pick = next_rand();
		idx = 4'(pick[7:0] % 8'd11);
		if (pick[31])
			word[31:26] = supported_ops_c[idx];
		return word;
	endfunction

	// Reference decoder with fields indexed from the least significant bit
	function automatic decoded_inst_t ref_decode(input logic [31:0] word);
		decoded_inst_t res;
		logic [5:0] pop;
		res = '0;
		pop = word[31:26];
		case (pop)
			6'd14: res.op = op_addi;
			6'd15: res.op = op_addis;
			6'd24: res.op = op_ori;
			6'd32: res.op = op_lwz;
			6'd34: res.op = op_lbz;
			6'd36: res.op = op_stw;
			6'd38: res.op = op_stb;
			6'd56: res.op = op_lq;
			6'd58: res.op = (word[1:0] == 2'd0) ? op_ld : (word[1:0] == 2'd1) ? op_ldu :
				(word[1:0] == 2'd2) ? op_lwa : op_none;
			6'd62: res.op = (word[1:0] == 2'd0) ? op_std : (word[1:0] == 2'd1) ? op_stdu : op_none;
			6'd61: res.op = (word[2:0] == 3'd1) ? op_lxv : (word[2:0] == 3'd5) ? op_stxv : op_none;
			default: res.op = op_none;
		endcase
		if (res.op == op_none)
		begin
			res.illegal = 1'b1;
			return res;
		end
		res.rt = word[25:21];
		res.ra = word[20:16];
		res.ra_or_zero = !(res.op inside {op_ori, op_ldu, op_stdu});
		if (pop == 6'd24)
			res.imm = {48'h0, word[15:0]};
		else if (pop == 6'd15)
			res.imm = {{32{word[15]}}, word[15:0], 16'h0000};
		else if (pop == 6'd58 || pop == 6'd62)
			res.imm = {{48{word[15]}}, word[15:2], 2'b00};
		else if (pop == 6'd56 || pop == 6'd61)
			res.imm = {{48{word[15]}}, word[15:4], 4'b0000};
		else
			res.imm = {{48{word[15]}}, word[15:0]};
		res.tx = (pop == 6'd61) && word[3];
		return res;
	endfunction

	task automatic compare_inst(input string name, input decoded_inst_t exp,
		input decoded_inst_t act);
		if (act !== exp)
		begin
			value_errors++;
			$display("error %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic compare_valid(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			value_errors++;
			$display("error %s expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic check_output();
		logic exp_valid;
		string name;
		if (exp_valid_q.size() == 0)
		begin
			other_errors++;
			$display("The output was sampled while no expected result was queued");
			return;
		end
		exp_valid = exp_valid_q.pop_front();
		name = exp_name_q.pop_front();
		compare_valid(name, exp_valid, valid_o);
		if (exp_valid)
			compare_inst(name, exp_inst_q.pop_front(), inst_o);
	endtask

	// Checks the result of the previous word, then presents the next one
	task automatic step(input string name, input logic valid, input logic [31:0] word);
		@(posedge clock_i);
		#1;
		check_output();
		valid_i = valid;
		instr_i = word;
		exp_valid_q.push_back(valid);
		exp_name_q.push_back(name);
		if (valid)
			exp_inst_q.push_back(ref_decode(word));
	endtask

	task automatic apply_reset(input string name);
		valid_i = 1'b0;
		arst_n_i = 1'b0;
		#1;
		compare_valid(name, 1'b0, valid_o); // Cleared without waiting for an edge
		compare_inst(name, '0, inst_o);
		repeat (2) @(posedge clock_i);
		#1;
		compare_valid(name, 1'b0, valid_o);
		arst_n_i = 1'b1;
		exp_valid_q.delete();
		exp_inst_q.delete();
		exp_name_q.delete();
		exp_valid_q.push_back(1'b0);
		exp_name_q.push_back(name);
	endtask

	task automatic run_directed();
		logic [31:0] rnd;
		logic [15:0] disp;
		logic [15:0] low;
		for (int i = 0; i < 15; i++)
			for (int v = 0; v < 3; v++)
			begin
				rnd = next_rand();
				disp = (v == 0) ? rnd[15:0] : (v == 1) ? 16'h7fff : 16'h8000;
				low = (disp & ~{12'h000, dir_mask_c[i]}) | {12'h000, dir_val_c[i]};
				step("directed", 1'b1, {dir_op_c[i], rnd[31:22], low});
			end
		step("directed", 1'b0, 32'h0);
	endtask

	task automatic run_edges();
		logic [31:0] word;
		for (int i = 0; i < 9; i++)
		begin
			word = next_rand();
			word[31:26] = edge_op_c[i];
			if (edge_op_c[i] == 6'd61)
				word[2:0] = edge_xo_c[i];
			else
				word[1:0] = edge_xo_c[i][1:0];
			step("ext_opcode", 1'b1, word);
		end
		step("ext_opcode", 1'b0, 32'h0);
	endtask

	initial
	begin
		logic [31:0] r;
		arst_n_i = 1'b1;
		valid_i = 1'b0;
		instr_i = '0;
		@(posedge clock_i);
		#1;
		apply_reset("reset");
		run_directed();
		run_edges();
		for (int i = 0; i < random_len_c; i++)
			step("random", 1'b1, rand_word());
		step("random", 1'b0, 32'h0);
		for (int i = 0; i < gap_len_c; i++)
		begin
			r = next_rand();
			step("valid_gaps", r[31:30] != 2'b00, rand_word()); // Idle about a quarter of the time
		end
		step("valid_gaps", 1'b0, 32'h0);
		for (int i = 0; i < mid_half_c; i++)
			step("reset_mid", 1'b1, rand_word());
		apply_reset("reset_mid");
		for (int i = 0; i < mid_half_c; i++)
			step("after_reset", 1'b1, rand_word());
		step("after_reset", 1'b0, 32'h0);
		$display("Finished with %0d value errors, %0d other errors and %0d assertion failures",
			value_errors, other_errors, i_dut.i_merge.i_asserts.fail_count);
		if (value_errors == 0 && other_errors == 0 && i_dut.i_merge.i_asserts.fail_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule
